// File: tb.f
+incdir+.
iwm_pkg.sv
iwm_window_timer.sv
iwm_read_fsm.sv
iwm_data_latch.sv
iwm_reg_read.sv
iwm_flux.sv
tb_iwm_flux.sv

// File: tb_iwm_tasks.svh
// ======================================================================
// Drive side and CPU bus tasks
// ======================================================================

// Top nbits of value go out MSB first, one bit cell each
task automatic send_flux_bits(input byte_t value, input integer nbits,
                              input integer cell_clks);
    integer i;
    integer c;
    for (i = 7; i > 7 - nbits; i = i - 1) begin
        for (c = 0; c < cell_clks; c = c + 1) begin
            @(posedge CLK_14M);
            FLUX_TRANSITION <= value[i] && (c == 4 || c == 5);  // Two-clock pulse for a one
        end
    end
endtask

// One CPU read with RD held across a single CEN strobe
task automatic read_register(input logic [3:0] addr, output byte_t value);
    @(posedge CLK_14M);
    ADDR <= addr;
    RD   <= 1'b1;
    @(negedge CLK_14M);
    while (!CEN) @(negedge CLK_14M);  // Bus cycle in which the DUT takes the read
    value = DATA_OUT;                 // Mid-cycle, inputs settled
    @(posedge CLK_14M);
    RD <= 1'b0;
    repeat (2) @(posedge CLK_14M);    // Read end registers here
endtask

// File: tb_iwm_flux.sv
`timescale 1ns/1ns

module tb_iwm_flux
    import iwm_pkg::*;
();

    localparam integer CELL_FAST  = 28;     // Clocks per bit cell at a 14 tick window
    localparam integer CELL_SLOW  = 56;     // Slow 5.25-inch cell
    localparam integer MAX_CYCLES = 40000;  // Twelve slow bytes of 448 clocks plus reads and margin

    logic       CLK_14M = 1'b0, RESET = 1'b1, CLK_7M_EN = 1'b0, CEN = 1'b0, RD = 1'b0;
    logic       SW_Q6 = 1'b0, SW_Q7 = 1'b0, FLUX_TRANSITION = 1'b0, SENSE_BIT = 1'b0;
    logic       MOTOR_ACTIVE = 1'b0, MOTOR_SPINNING = 1'b0, DISK_READY = 1'b0;
    logic       DISK_MOUNTED = 1'b0, IS_35_INCH = 1'b0;
    logic [3:0] ADDR = 4'h0;
    byte_t      SW_MODE = 8'h00;
    byte_t      DATA_OUT;

    integer      seed = 32'h8447;
    integer      cycle_count = 0;
    integer      i;
    logic [1:0]  cen_phase = 2'd0;
    logic [31:0] r;
    byte_t       sent_q[$];  // Bytes written to the disk, oldest first
    byte_t       b;
    byte_t       got;

    iwm_flux i_dut (
        .CLK_14M(CLK_14M), .RESET(RESET), .CLK_7M_EN(CLK_7M_EN), .CEN(CEN), .ADDR(ADDR),
        .RD(RD), .SW_Q6(SW_Q6), .SW_Q7(SW_Q7), .SW_MODE(SW_MODE),
        .FLUX_TRANSITION(FLUX_TRANSITION), .MOTOR_ACTIVE(MOTOR_ACTIVE),
        .MOTOR_SPINNING(MOTOR_SPINNING), .DISK_READY(DISK_READY),
        .DISK_MOUNTED(DISK_MOUNTED), .IS_35_INCH(IS_35_INCH), .SENSE_BIT(SENSE_BIT),
        .DATA_OUT(DATA_OUT)
    );

    `include "tb_iwm_tasks.svh"

    // ======================================================================
    // Clock, enables and run limit
    // ======================================================================

    always #5 CLK_14M = ~CLK_14M;

    always @(posedge CLK_14M) begin
        CLK_7M_EN <= ~CLK_7M_EN;            // 7 MHz tick every other clock
        cen_phase <= cen_phase + 2'd1;
        CEN       <= (cen_phase == 2'd3);   // Bus strobe one clock in four
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "Timeout");
        end
    end

    task automatic expect_byte(input byte_t seen, input byte_t want, input string what);
        assert (seen === want) else begin
            $display("FAIL at %0t ns: %s read %h, expected %h", $time, what, seen, want);
            $display("Simulation FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Q7 high and Q6 low always shows the empty write buffer
    always @(negedge CLK_14M) begin
        if (!RESET && ADDR == 4'hF && !SW_Q6) expect_byte(DATA_OUT, 8'h80, "handshake");
    end

    function automatic byte_t random_byte();
        logic [31:0] raw;
        raw = $random(seed);
        return raw[7:0] | 8'h80;             // Top bit on so the byte completes
    endfunction

    // Data reads until a completed byte shows up
    task automatic wait_for_byte(output byte_t value);
        integer tries;
        tries = 0;
        read_register(4'hC, value);
        while (!value[7] && tries < 100) begin
            read_register(4'hC, value);
            tries = tries + 1;
        end
    endtask

    task automatic send_and_check(input integer cell_clks, input string what);
        byte_t value;
        byte_t seen;
        value = random_byte();
        send_flux_bits(value, 8, cell_clks);
        wait_for_byte(seen);
        expect_byte(seen, value, what);
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        repeat (8) @(posedge CLK_14M);
        RESET <= 1'b0;
        read_register(4'hC, got);            // Motor off
        expect_byte(got, 8'hFF, "data with motor off");
        read_register(4'hF, got);
        expect_byte(got, 8'h80, "handshake");
        @(posedge CLK_14M);
        SW_Q6 <= 1'b1;
        read_register(4'hF, got);
        expect_byte(got, 8'hFF, "Q7 and Q6 high");
        @(posedge CLK_14M);
        SW_Q6 <= 1'b0;
        for (i = 0; i < 4; i = i + 1) begin  // Status for random mode and sense lines
            r = $random(seed);
            @(posedge CLK_14M);
            SW_MODE      <= r[7:0];
            SENSE_BIT    <= r[8];
            MOTOR_ACTIVE <= i[0];             // Every motor and mounted pair
            DISK_MOUNTED <= i[1];
            read_register(4'hD, got);
            expect_byte(got, {r[8], 1'b0, i[0] & i[1], r[4:0]}, "status");
        end
        @(posedge CLK_14M);
        SW_MODE        <= 8'h00;             // Sync mode and a spinning 3.5-inch drive
        MOTOR_ACTIVE   <= 1'b1;
        MOTOR_SPINNING <= 1'b1;
        DISK_READY     <= 1'b1;
        DISK_MOUNTED   <= 1'b1;
        IS_35_INCH     <= 1'b1;
        repeat (8) sent_q.push_back(random_byte());
        while (sent_q.size() > 0) begin
            b = sent_q.pop_front();
            send_flux_bits(b, 8, CELL_FAST);
            wait_for_byte(got);
            expect_byte(got, b, "sync byte");
            read_register(4'hC, got);
            expect_byte(got, b, "sync repeat read");
        end
        @(posedge CLK_14M);
        IS_35_INCH <= 1'b0;                  // Slow 5.25-inch window
        repeat (2) send_and_check(CELL_SLOW, "slow 5.25 byte");
        @(posedge CLK_14M);
        SW_MODE <= 8'h08;                    // Fast mode on the 5.25-inch drive
        repeat (2) send_and_check(CELL_FAST, "fast 5.25 byte");
        @(posedge CLK_14M);
        IS_35_INCH <= 1'b1;
        SW_MODE    <= 8'h02;                 // Async mode
        b = random_byte();
        send_flux_bits(b, 8, CELL_FAST);
        read_register(4'hC, got);
        expect_byte(got, b, "async first read");
        read_register(4'hC, got);
        expect_byte(got, b & 8'h7F, "async masked read");
        repeat (40) @(posedge CLK_14M);      // 20 ticks is past the clear
        read_register(4'hC, got);
        expect_byte(got, 8'h00, "async cleared data");
        @(posedge CLK_14M);
        SW_MODE <= 8'h00;
        send_flux_bits(random_byte(), 4, CELL_FAST);  // Half a byte before ready drops
        DISK_READY <= 1'b0;
        repeat (40) @(posedge CLK_14M);
        DISK_READY <= 1'b1;
        send_and_check(CELL_FAST, "byte after ready drop");
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: iwm_flux.sv
`timescale 1ns/1ns

module iwm_flux
    import iwm_pkg::*;
#(
    parameter win_cnt_t   WIN_FAST    = DEF_WIN_FAST,
    parameter win_cnt_t   WIN_SLOW    = DEF_WIN_SLOW,
    parameter async_cnt_t ASYNC_CLEAR = DEF_ASYNC_CLEAR
) (
    input  logic       CLK_14M,
    input  logic       RESET,
    input  logic       CLK_7M_EN,        // Decoder tick
    input  logic       CEN,
    input  logic [3:0] ADDR,
    input  logic       RD,
    input  logic       SW_Q6,
    input  logic       SW_Q7,
    input  byte_t      SW_MODE,
    input  logic       FLUX_TRANSITION,
    input  logic       MOTOR_ACTIVE,     // Motor command, not gated by disk
    input  logic       MOTOR_SPINNING,
    input  logic       DISK_READY,
    input  logic       DISK_MOUNTED,
    input  logic       IS_35_INCH,
    input  logic       SENSE_BIT,
    output byte_t      DATA_OUT
);

    logic  disk_active;
    logic  load_full, load_half, expire;
    logic  shift_bit, bit_val, clear_rsh;
    logic  data_read_done;
    byte_t data_value;

    assign disk_active = MOTOR_SPINNING && DISK_READY;

    iwm_window_timer #(.WIN_FAST(WIN_FAST), .WIN_SLOW(WIN_SLOW)) i_timer (
        .CLK_14M, .RESET, .tick(CLK_7M_EN), .is_35_inch(IS_35_INCH),
        .fast_mode(SW_MODE[3]), .load_full, .load_half, .expire
    );

    iwm_read_fsm i_fsm (
        .CLK_14M, .RESET, .tick(CLK_7M_EN), .disk_active, .flux(FLUX_TRANSITION),
        .expire, .load_full, .load_half, .shift_bit, .bit_val, .clear_rsh
    );

    iwm_data_latch #(.ASYNC_CLEAR(ASYNC_CLEAR)) i_latch (
        .CLK_14M, .RESET, .tick(CLK_7M_EN), .disk_active, .motor_active(MOTOR_ACTIVE),
        .async_mode(SW_MODE[1]), .shift_bit, .bit_val, .clear_rsh, .data_read_done,
        .data_value
    );

    iwm_reg_read i_reg_read (
        .CLK_14M, .RESET, .CEN, .RD, .ADDR, .SW_Q6, .SW_Q7, .motor_active(MOTOR_ACTIVE),
        .disk_mounted(DISK_MOUNTED), .sense_bit(SENSE_BIT), .mode(SW_MODE), .data_value,
        .data_read_done, .DATA_OUT
    );

endmodule

// File: iwm_reg_read.sv
`timescale 1ns/1ns

module iwm_reg_read
    import iwm_pkg::*;
(
    input  logic       CLK_14M,
    input  logic       RESET,
    input  logic       CEN,             // CPU bus phase strobe
    input  logic       RD,
    input  logic [3:0] ADDR,            // Low nibble of the IWM address
    input  logic       SW_Q6,           // Latched Q6
    input  logic       SW_Q7,           // Latched Q7
    input  logic       motor_active,
    input  logic       disk_mounted,
    input  logic       sense_bit,       // Drive status sense line
    input  byte_t      mode,            // Mode register
    input  byte_t      data_value,
    output logic       data_read_done,  // Falling end of a data register read
    output byte_t      DATA_OUT
);

    logic     imm_q6;
    logic     imm_q7;
    reg_sel_t sel;
    logic     rd_latched;  // Current CPU read already taken
    logic     data_read;   // Current read selected the data register
    logic     rd_start;
    logic     rd_end;

    // Access to the Q6/Q7 switch itself overrides the latched value
    assign imm_q6 = (ADDR[3:1] == 3'b110) ? ADDR[0] : SW_Q6;
    assign imm_q7 = (ADDR[3:1] == 3'b111) ? ADDR[0] : SW_Q7;
    assign sel    = reg_sel_t'({imm_q7, imm_q6});

    assign rd_start       = RD && CEN && !rd_latched;      // First cycle of the read
    assign rd_end         = rd_latched && (!RD || !CEN);
    assign data_read_done = rd_end && data_read;

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            rd_latched <= 1'b0;
            data_read  <= 1'b1;
        end else if (rd_end) begin
            rd_latched <= 1'b0;
        end else if (rd_start) begin
            rd_latched <= 1'b1;
            data_read  <= (sel == SEL_DATA);
        end
    end

    // Read multiplexer
    always_comb begin
        case (sel)
            SEL_DATA:      DATA_OUT = motor_active ? data_value : 8'hFF;
            SEL_STATUS:    DATA_OUT = {sense_bit, 1'b0, motor_active && disk_mounted,
                                       mode[4:0]};
            SEL_HANDSHAKE: DATA_OUT = HANDSHAKE_VALUE;
            default:       DATA_OUT = 8'hFF;  // Q7 and Q6 both set
        endcase
    end

endmodule

// File: iwm_data_latch.sv
`timescale 1ns/1ns

module iwm_data_latch
    import iwm_pkg::*;
#(
    parameter async_cnt_t ASYNC_CLEAR = DEF_ASYNC_CLEAR
) (
    input  logic  CLK_14M,
    input  logic  RESET,
    input  logic  tick,            // 7 MHz enable
    input  logic  disk_active,
    input  logic  motor_active,    // Motor command on
    input  logic  async_mode,      // Mode register bit 1
    input  logic  shift_bit,
    input  logic  bit_val,
    input  logic  clear_rsh,
    input  logic  data_read_done,  // End of a CPU data register read
    output byte_t data_value       // Byte as the CPU sees it
);

    byte_t      rsh;        // Read shift register
    byte_t      data_reg;   // Last completed byte
    logic       ack;        // Top bit already seen by the CPU
    async_cnt_t async_cnt;  // Ticks left until the async clear
    logic       byte_completing;
    byte_t      data_raw;
    logic       mask_top;

    // ======================================================================
    // CPU view of the data register
    // ======================================================================

    // A byte is done once a one reaches the top of the shift register
    assign byte_completing = rsh[7] && disk_active;
    assign data_raw        = byte_completing ? rsh : data_reg;  // Same-cycle bypass

    // Never mask a byte that is landing right now
    assign mask_top   = motor_active && async_mode && ack && !byte_completing;
    assign data_value = mask_top ? (data_raw & 8'h7F) : data_raw;

    // ======================================================================
    // Shift register, data register and async clear
    // ======================================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            rsh       <= '0;
            data_reg  <= '0;
            ack       <= 1'b0;
            async_cnt <= '0;
        end else begin
            if (clear_rsh) begin
                rsh <= '0;
            end else if (shift_bit) begin
                rsh <= {rsh[6:0], bit_val};  // MSB first off the disk
            end

            // Countdown after an acknowledged read
            if (tick && (async_cnt != '0)) begin
                if ((async_cnt == async_cnt_t'(1)) && async_mode && !byte_completing) begin
                    data_reg <= '0;
                    ack      <= 1'b0;
                end
                async_cnt <= async_cnt - async_cnt_t'(1);
            end

            // First read of a valid byte in async mode
            if (data_read_done && motor_active && async_mode && data_raw[7] &&
                !byte_completing) begin
                ack <= 1'b1;
                if (async_cnt == '0) async_cnt <= ASYNC_CLEAR;  // Running count kept
            end

            // Byte complete, new byte cancels any pending clear
            if (tick && byte_completing) begin
                data_reg  <= rsh;
                rsh       <= '0;
                ack       <= 1'b0;
                async_cnt <= '0;
            end

            if (!disk_active) begin
                ack       <= 1'b0;
                async_cnt <= '0;
            end
        end
    end

endmodule

// File: iwm_read_fsm.sv
`timescale 1ns/1ns

module iwm_read_fsm
    import iwm_pkg::*;
(
    input  logic CLK_14M,
    input  logic RESET,
    input  logic tick,         // 7 MHz enable
    input  logic disk_active,  // Motor spinning and track data valid
    input  logic flux,         // Flux reversal level from the drive
    input  logic expire,       // Window timer at its last tick
    output logic load_full,
    output logic load_half,
    output logic shift_bit,    // Strobe a decoded bit into the shift register
    output logic bit_val,
    output logic clear_rsh     // Restart byte assembly
);

    rw_state_t state;
    logic      prev_flux;
    logic      flux_seen;      // Edge caught at 14 MHz, held until a tick
    logic      flux_pending;   // Edge caught during edge-1, used on return
    logic      flux_edge;
    logic      step;           // Decoder advances this cycle

    assign flux_edge = flux && !prev_flux;
    assign step      = tick && disk_active;

    // ======================================================================
    // Strobes to the timer and the shift register
    // ======================================================================

    always_comb begin
        load_full = 1'b0;
        load_half = 1'b0;
        shift_bit = 1'b0;
        bit_val   = 1'b0;
        clear_rsh = 1'b0;
        if (step) begin
            case (state)
                ST_IDLE: begin
                    load_full = 1'b1;   // Start first window
                    clear_rsh = 1'b1;   // Partial bits are dropped
                end
                ST_EDGE_0: begin
                    if (flux_seen || flux_pending) begin
                        load_half = 1'b1;  // Flux wins over a same-tick expire
                    end else if (expire) begin
                        shift_bit = 1'b1;  // Empty window is a zero
                        load_full = 1'b1;
                    end
                end
                ST_EDGE_1: begin
                    if (expire) begin
                        shift_bit = 1'b1;
                        bit_val   = 1'b1;  // Flux in the window is a one
                        load_full = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // ======================================================================
    // State and flux capture
    // ======================================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            state        <= ST_IDLE;
            prev_flux    <= 1'b0;
            flux_seen    <= 1'b0;
            flux_pending <= 1'b0;
        end else begin
            prev_flux <= flux;
            // Every active tick consumes the capture, a new edge always lands
            flux_seen <= disk_active && (flux_edge || (flux_seen && !tick));
            if (!disk_active) begin
                state        <= ST_IDLE;
                flux_pending <= 1'b0;
            end else if (tick) begin
                case (state)
                    ST_IDLE: state <= ST_EDGE_0;
                    ST_EDGE_0: begin
                        if (flux_seen || flux_pending) begin
                            state        <= ST_EDGE_1;
                            flux_pending <= 1'b0;
                        end
                    end
                    ST_EDGE_1: begin
                        if (flux_seen) flux_pending <= 1'b1;  // Early flux of the next one
                        if (expire) state <= ST_EDGE_0;
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

endmodule

// File: iwm_window_timer.sv
`timescale 1ns/1ns

module iwm_window_timer
    import iwm_pkg::*;
#(
    parameter win_cnt_t WIN_FAST = DEF_WIN_FAST,
    parameter win_cnt_t WIN_SLOW = DEF_WIN_SLOW
) (
    input  logic CLK_14M,
    input  logic RESET,
    input  logic tick,        // 7 MHz enable
    input  logic is_35_inch,
    input  logic fast_mode,   // Mode register bit 3
    input  logic load_full,
    input  logic load_half,
    output logic expire       // Last tick of the current window
);

    win_cnt_t count;
    win_cnt_t full_win;
    win_cnt_t half_win;

    // 3.5-inch drives always run the short window
    assign full_win = (is_35_inch || fast_mode) ? WIN_FAST : WIN_SLOW;
    assign half_win = full_win >> 1;  // Half window is always half

    assign expire = tick && (count == win_cnt_t'(1));

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            count <= '0;
        end else if (load_full) begin
            count <= full_win;                 // Loads win over the decrement
        end else if (load_half) begin
            count <= half_win;
        end else if (tick && (count != '0)) begin
            count <= count - win_cnt_t'(1);    // Holds at zero while idle
        end
    end

endmodule

// File: iwm_pkg.sv
package iwm_pkg;

    // ======================================================================
    // Shared widths
    // ======================================================================

    typedef logic [7:0] byte_t;       // Data, status or shift register byte
    typedef logic [5:0] win_cnt_t;    // Bit window count in 7 MHz ticks
    typedef logic [5:0] async_cnt_t;  // Async clear countdown in ticks

    // ======================================================================
    // Read decoder states
    // ======================================================================

    typedef enum logic [1:0] {
        ST_IDLE,    // Disk inactive or just restarted
        ST_EDGE_0,  // Waiting for flux within a full window
        ST_EDGE_1   // Flux seen, waiting out half a window
    } rw_state_t;

    // Q7/Q6 register choice for a CPU read
    typedef enum logic [1:0] {
        SEL_DATA      = 2'b00,
        SEL_STATUS    = 2'b01,
        SEL_HANDSHAKE = 2'b10,
        SEL_ONES      = 2'b11
    } reg_sel_t;

    // ======================================================================
    // Default timing, in 7 MHz ticks
    // ======================================================================

    localparam win_cnt_t   DEF_WIN_FAST    = 6'd14;  // 3.5-inch drive or fast mode
    localparam win_cnt_t   DEF_WIN_SLOW    = 6'd28;  // 5.25-inch drive, slow mode
    localparam async_cnt_t DEF_ASYNC_CLEAR = 6'd14;  // About 2 us at 7 MHz

    // Write handshake read value, write path not present so buffer always empty
    localparam byte_t HANDSHAKE_VALUE = 8'h80;

endpackage
